/* hdl/ahbl_pkg.sv */
/*
 * Shared constants for the AHB-Lite fill and check subsystem.
 * Holds bus widths, transfer and burst codes, the APB register map and the
 * bit positions of the monitor's sticky violation flags.
 */
package ahbl_pkg;

	// Default bus widths, one word each
	localparam int AHB_ADDR_W = 32;
	localparam int AHB_DATA_W = 32;

	// HTRANS codes, the engine never issues BUSY
	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ  = 2'b11;

	// Only undefined-length incrementing bursts are used
	localparam logic [2:0] HBURST_INCR = 3'b001;

	// APB register byte offsets
	localparam logic [7:0] REG_CTRL    = 8'h00;
	localparam logic [7:0] REG_BASE    = 8'h04;
	localparam logic [7:0] REG_COUNT   = 8'h08;
	localparam logic [7:0] REG_PATTERN = 8'h0c;
	localparam logic [7:0] REG_STATUS  = 8'h10;
	localparam logic [7:0] REG_RESULT  = 8'h14;
	localparam logic [7:0] REG_XFER    = 8'h18;
	localparam logic [7:0] REG_STALL   = 8'h1c;
	localparam logic [7:0] REG_VIOL    = 8'h20;

	// Bit positions inside the 6-bit violation word
	localparam int VIOL_ALIGN    = 0;
	localparam int VIOL_SIZE     = 1;
	localparam int VIOL_HOLD     = 2;
	localparam int VIOL_SEQ_IDLE = 3;
	localparam int VIOL_SEQ_ADDR = 4;
	localparam int VIOL_WDATA    = 5;

endpackage

/* hdl/apb_regs.sv */
/*
 * APB register block of the fill and check engine.
 * Holds the burst configuration, the done flag and irq, and decodes
 * register reads from the engine and the bus monitor without wait states.
 */
module apb_regs (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [7:0]                      paddr,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [31:0]                     pwdata,
	output logic [31:0]                     prdata,
	input  logic                            busy,
	input  logic                            done_pulse,
	input  logic [ahbl_pkg::AHB_DATA_W-1:0] result_sum,
	input  logic [15:0]                     nseq_count,
	input  logic [15:0]                     seq_count,
	input  logic [31:0]                     stall_count,
	input  logic [5:0]                      viol_flags,
	output logic                            start_pulse,
	output logic                            mode_write,
	output logic [2:0]                      xfer_size,
	output logic [ahbl_pkg::AHB_ADDR_W-1:0] base_addr,
	output logic [15:0]                     beat_count,
	output logic [ahbl_pkg::AHB_DATA_W-1:0] pattern,
	output logic                            clear_counts,
	output logic [5:0]                      viol_clear,
	output logic                            irq
);
	import ahbl_pkg::*;

	logic                  wr_access;
	logic                  start_q;
	logic                  mode_q;
	logic [2:0]            size_q;
	logic [AHB_ADDR_W-1:0] base_q;
	logic [15:0]           count_q;
	logic [AHB_DATA_W-1:0] pattern_q;
	logic                  done_q;

	// Writes land at the end of the access cycle
	assign wr_access = psel && penable && pwrite;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q   <= 1'b0;
			mode_q    <= 1'b0;
			size_q    <= 3'd0;
			base_q    <= '0;
			count_q   <= 16'd0;
			pattern_q <= '0;
			done_q    <= 1'b0;
		end else begin
			// Start bit self-clears after one cycle, ignored while a burst runs
			start_q <= wr_access && (paddr == REG_CTRL) && pwdata[0] && !busy;
			if (wr_access) begin
				case (paddr)
					REG_CTRL: begin
						mode_q <= pwdata[1];
						size_q <= pwdata[4:2];
					end
					REG_BASE:    base_q    <= pwdata[AHB_ADDR_W-1:0];
					REG_COUNT:   count_q   <= pwdata[15:0];
					REG_PATTERN: pattern_q <= pwdata[AHB_DATA_W-1:0];
					default: ;
				endcase
			end
			// Completion sets done, a write of 1 to bit 1 clears it
			if (done_pulse)
				done_q <= 1'b1;
			else if (wr_access && (paddr == REG_STATUS) && pwdata[1])
				done_q <= 1'b0;
		end
	end

	// Engine controls
	assign start_pulse  = start_q;
	assign clear_counts = start_q;
	assign mode_write   = mode_q;
	assign xfer_size    = size_q;
	assign base_addr    = base_q;
	assign beat_count   = count_q;
	assign pattern      = pattern_q;
	assign irq          = done_q;

	// Write-1 clear mask for the monitor flags
	assign viol_clear = (wr_access && (paddr == REG_VIOL)) ? pwdata[5:0] : 6'd0;

	// Read mux, valid in the access cycle
	always_comb begin
		case (paddr)
			REG_CTRL:    prdata = {27'd0, size_q, mode_q, start_q};
			REG_BASE:    prdata = 32'(base_q);
			REG_COUNT:   prdata = {16'd0, count_q};
			REG_PATTERN: prdata = 32'(pattern_q);
			REG_STATUS:  prdata = {30'd0, done_q, busy};
			REG_RESULT:  prdata = 32'(result_sum);
			REG_XFER:    prdata = {seq_count, nseq_count};
			REG_STALL:   prdata = stall_count;
			REG_VIOL:    prdata = {26'd0, viol_flags};
			default:     prdata = 32'd0;
		endcase
	end

endmodule

/* hdl/ahbl_burst_master.sv */
/*
 * AHB-Lite master that runs one programmed INCR burst per start pulse.
 * Write mode stores pattern plus beat index, read mode sums the addressed
 * lanes. Address and data phases overlap by one beat.
 */
module ahbl_burst_master #(
	parameter int ADDR_W = ahbl_pkg::AHB_ADDR_W,
	parameter int DATA_W = ahbl_pkg::AHB_DATA_W
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start_pulse,
	input  logic              mode_write,
	input  logic [2:0]        xfer_size,
	input  logic [ADDR_W-1:0] base_addr,
	input  logic [15:0]       beat_count,
	input  logic [DATA_W-1:0] pattern,
	input  logic              hready,
	input  logic [DATA_W-1:0] hrdata,
	output logic [ADDR_W-1:0] haddr,
	output logic              hwrite,
	output logic [1:0]        htrans,
	output logic [2:0]        hsize,
	output logic [2:0]        hburst,
	output logic [DATA_W-1:0] hwdata,
	output logic              busy,
	output logic              done_pulse,
	output logic [DATA_W-1:0] result_sum
);
	import ahbl_pkg::*;

	localparam int LANES = DATA_W / 8;
	localparam int OFS_W = $clog2(LANES);

	logic              mode_q;
	logic [2:0]        size_q;
	logic [15:0]       count_q;
	logic [DATA_W-1:0] pattern_q;
	logic [15:0]       issue_idx;
	logic              last_addr;
	logic              dph_active;
	logic              dph_last;
	logic [OFS_W-1:0]  dph_ofs;
	logic [ADDR_W-1:0] addr_step;
	logic              launch;
	logic              addr_done;

	// Replicate one size unit of the value across every byte lane
	function automatic logic [DATA_W-1:0] lane_fill(input logic [DATA_W-1:0] v,
			input logic [2:0] size);
		logic [DATA_W-1:0] w;
		int unsigned       unit;
		unit = (size >= OFS_W) ? LANES : (1 << size);
		for (int b = 0; b < LANES; b++)
			w[8*b +: 8] = v[8*(b % unit) +: 8];
		return w;
	endfunction

	// Addressed lanes of the read word, shifted down and zero-extended
	function automatic logic [DATA_W-1:0] lane_pick(input logic [DATA_W-1:0] d,
			input logic [OFS_W-1:0] ofs, input logic [2:0] size);
		logic [DATA_W-1:0] mask;
		if (size >= OFS_W)
			return d;
		mask = ~({DATA_W{1'b1}} << (8 << size));
		return (d >> (8 * ofs)) & mask;
	endfunction

	assign launch    = start_pulse && !busy;
	assign addr_done = busy && hready && htrans[1];
	assign last_addr = (issue_idx == count_q - 16'd1);
	// Step is one size unit, not one bus word
	assign addr_step = ADDR_W'(1) << size_q;

	assign hwrite = mode_q;
	assign hsize  = size_q;
	assign hburst = HBURST_INCR;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			htrans     <= HTRANS_IDLE;
			haddr      <= '0;
			mode_q     <= 1'b0;
			size_q     <= 3'd0;
			issue_idx  <= 16'd0;
			dph_active <= 1'b0;
			dph_last   <= 1'b0;
			done_pulse <= 1'b0;
			result_sum <= '0;
		end else begin
			done_pulse <= 1'b0;
			if (launch) begin
				mode_q     <= mode_write;
				size_q     <= xfer_size;
				haddr      <= base_addr;
				issue_idx  <= 16'd0;
				result_sum <= '0;
				dph_active <= 1'b0;
				// Zero beats finish at once without touching the bus
				if (beat_count != 16'd0) begin
					busy   <= 1'b1;
					htrans <= HTRANS_NSEQ;
				end else begin
					done_pulse <= 1'b1;
				end
			end else if (busy && hready) begin
				// Address phase accepted, move on to the next beat
				if (htrans[1]) begin
					haddr <= haddr + addr_step;
					if (last_addr) begin
						htrans <= HTRANS_IDLE;
					end else begin
						htrans    <= HTRANS_SEQ;
						issue_idx <= issue_idx + 16'd1;
					end
				end
				dph_active <= htrans[1];
				dph_last   <= last_addr;
				// Data phase completes on this edge
				if (dph_active) begin
					if (!mode_q)
						result_sum <= result_sum + lane_pick(hrdata, dph_ofs, size_q);
					if (dph_last) begin
						busy       <= 1'b0;
						done_pulse <= 1'b1;
					end
				end
			end
		end
	end

	// Beat payload, held through wait states since it only moves on hready
	always_ff @(posedge clk) begin
		if (launch) begin
			count_q   <= beat_count;
			pattern_q <= pattern;
		end
		if (addr_done) begin
			hwdata  <= lane_fill(pattern_q + DATA_W'(issue_idx), size_q);
			dph_ofs <= haddr[OFS_W-1:0];
		end
	end

endmodule

/* hdl/ahbl_sram.sv */
/*
 * AHB-Lite SRAM slave with byte lanes and a fixed wait-state count.
 * Every data phase holds hready low for WAIT_STATES cycles, and the word
 * index wraps modulo DEPTH. Always answers OKAY.
 */
module ahbl_sram #(
	parameter int ADDR_W      = ahbl_pkg::AHB_ADDR_W,
	parameter int DATA_W      = ahbl_pkg::AHB_DATA_W,
	parameter int DEPTH       = 1024,
	parameter int WAIT_STATES = 0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [ADDR_W-1:0] haddr,
	input  logic              hwrite,
	input  logic [1:0]        htrans,
	input  logic [2:0]        hsize,
	input  logic [DATA_W-1:0] hwdata,
	output logic              hready,
	output logic [DATA_W-1:0] hrdata
);
	localparam int LANES  = DATA_W / 8;
	localparam int OFS_W  = $clog2(LANES);
	localparam int IDX_W  = $clog2(DEPTH);
	localparam int WCNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [DATA_W-1:0] mem [DEPTH];
	logic              dph_active;
	logic              dph_write;
	logic [IDX_W-1:0]  dph_idx;
	logic [OFS_W-1:0]  dph_ofs;
	logic [2:0]        dph_size;
	logic [WCNT_W-1:0] wait_cnt;
	logic [LANES-1:0]  wr_strb;

	// Byte enables from size and low address bits
	function automatic logic [LANES-1:0] lane_strobe(input logic [OFS_W-1:0] ofs,
			input logic [2:0] size);
		if (size >= OFS_W)
			return '1;
		return LANES'((1 << (1 << size)) - 1) << ofs;
	endfunction

	// Ready once the wait count is used up
	assign hready  = !dph_active || (wait_cnt == WCNT_W'(WAIT_STATES));
	assign hrdata  = mem[dph_idx];
	assign wr_strb = lane_strobe(dph_ofs, dph_size);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active <= 1'b0;
			dph_write  <= 1'b0;
			wait_cnt   <= '0;
		end else if (hready) begin
			dph_active <= htrans[1];
			dph_write  <= hwrite;
			wait_cnt   <= '0;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// Address phase capture
	always_ff @(posedge clk) begin
		if (hready && htrans[1]) begin
			dph_idx  <= IDX_W'((haddr >> OFS_W) % DEPTH);
			dph_ofs  <= haddr[OFS_W-1:0];
			dph_size <= hsize;
		end
	end

	// Write lanes on the last cycle of a write data phase
	always_ff @(posedge clk) begin
		if (dph_active && dph_write && hready) begin
			for (int b = 0; b < LANES; b++)
				if (wr_strb[b])
					mem[dph_idx][8*b +: 8] <= hwdata[8*b +: 8];
		end
	end

endmodule

/* hdl/ahbl_master_monitor.sv */
/*
 * Passive AHB-Lite master monitor.
 * Tracks the data phase, counts NONSEQ and SEQ beats and stall cycles, and
 * latches sticky protocol violation flags with one cycle of latency.
 */
module ahbl_master_monitor #(
	parameter int ADDR_W = ahbl_pkg::AHB_ADDR_W,
	parameter int DATA_W = ahbl_pkg::AHB_DATA_W
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [ADDR_W-1:0] haddr,
	input  logic              hwrite,
	input  logic [1:0]        htrans,
	input  logic [2:0]        hsize,
	input  logic [2:0]        hburst,
	input  logic [DATA_W-1:0] hwdata,
	input  logic              hready,
	input  logic              clear_counts,
	input  logic [5:0]        viol_clear,
	output logic [15:0]       nseq_count,
	output logic [15:0]       seq_count,
	output logic [31:0]       stall_count,
	output logic [5:0]        viol_flags
);
	import ahbl_pkg::*;

	// htrans, hwrite, haddr, hsize, hburst
	localparam int REQ_W = 2 + 1 + ADDR_W + 3 + 3;

	logic              dph_active;
	logic              dph_write;
	logic [ADDR_W-1:0] dph_addr;
	logic [2:0]        dph_size;
	logic              stalled_q;
	logic              hready_q;
	logic [REQ_W-1:0]  req_q;
	logic [DATA_W-1:0] hwdata_q;
	logic [REQ_W-1:0]  req_now;
	logic              req_active;
	logic [5:0]        viol_now;

	assign req_now    = {htrans, hwrite, haddr, hsize, hburst};
	assign req_active = (htrans != HTRANS_IDLE);

	always_comb begin
		viol_now = 6'd0;
		// Natural alignment and size checks on any active request
		if (req_active) begin
			viol_now[VIOL_ALIGN] = |(haddr & ~({ADDR_W{1'b1}} << hsize));
			viol_now[VIOL_SIZE]  = (8 << hsize) > DATA_W;
		end
		// Stalled request must not move or drop
		viol_now[VIOL_HOLD] = stalled_q && (req_now != req_q);
		if (htrans == HTRANS_SEQ) begin
			viol_now[VIOL_SEQ_IDLE] = !dph_active;
			// INCR only, one size unit past the beat now in data phase
			viol_now[VIOL_SEQ_ADDR] = haddr != dph_addr + (ADDR_W'(1) << dph_size);
		end
		// Same write data phase as last cycle, data must hold
		viol_now[VIOL_WDATA] = dph_active && dph_write && !hready_q && (hwdata != hwdata_q);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active  <= 1'b0;
			dph_write   <= 1'b0;
			dph_addr    <= '0;
			dph_size    <= 3'd0;
			stalled_q   <= 1'b0;
			hready_q    <= 1'b1;
			nseq_count  <= 16'd0;
			seq_count   <= 16'd0;
			stall_count <= 32'd0;
			viol_flags  <= 6'd0;
		end else begin
			if (hready) begin
				dph_active <= req_active;
				dph_write  <= hwrite;
				dph_addr   <= haddr;
				dph_size   <= hsize;
			end
			stalled_q  <= req_active && !hready;
			hready_q   <= hready;
			viol_flags <= (viol_flags & ~viol_clear) | viol_now;
			if (clear_counts) begin
				nseq_count  <= 16'd0;
				seq_count   <= 16'd0;
				stall_count <= 32'd0;
			end else begin
				// Beats count when their address phase is accepted
				if (hready && (htrans == HTRANS_NSEQ))
					nseq_count <= nseq_count + 16'd1;
				if (hready && (htrans == HTRANS_SEQ))
					seq_count <= seq_count + 16'd1;
				if (dph_active && !hready)
					stall_count <= stall_count + 32'd1;
			end
		end
	end

	// Previous-cycle copies for the hold checks
	always_ff @(posedge clk) begin
		req_q    <= req_now;
		hwdata_q <= hwdata;
	end

endmodule

/* hdl/ahbl_subsys_top.sv */
/*
 * Top level of the AHB-Lite fill and check subsystem.
 * Connects the APB register block, the burst engine, the SRAM and the
 * protocol monitor. Only the APB port and irq leave the block.
 */
module ahbl_subsys_top #(
	parameter int ADDR_W      = ahbl_pkg::AHB_ADDR_W,
	parameter int DATA_W      = ahbl_pkg::AHB_DATA_W,
	parameter int SRAM_DEPTH  = 1024,
	parameter int WAIT_STATES = 1
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        irq
);
	// Register block to engine
	logic              start_pulse;
	logic              mode_write;
	logic [2:0]        xfer_size;
	logic [ADDR_W-1:0] base_addr;
	logic [15:0]       beat_count;
	logic [DATA_W-1:0] pattern;
	logic              busy;
	logic              done_pulse;
	logic [DATA_W-1:0] result_sum;

	// AHB-Lite bus
	logic [ADDR_W-1:0] haddr;
	logic              hwrite;
	logic [1:0]        htrans;
	logic [2:0]        hsize;
	logic [2:0]        hburst;
	logic [DATA_W-1:0] hwdata;
	logic              hready;
	logic [DATA_W-1:0] hrdata;

	// Monitor results and clears
	logic [15:0]       nseq_count;
	logic [15:0]       seq_count;
	logic [31:0]       stall_count;
	logic [5:0]        viol_flags;
	logic              clear_counts;
	logic [5:0]        viol_clear;

	apb_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata),
		.busy(busy), .done_pulse(done_pulse), .result_sum(result_sum),
		.nseq_count(nseq_count), .seq_count(seq_count),
		.stall_count(stall_count), .viol_flags(viol_flags),
		.start_pulse(start_pulse), .mode_write(mode_write), .xfer_size(xfer_size),
		.base_addr(base_addr), .beat_count(beat_count), .pattern(pattern),
		.clear_counts(clear_counts), .viol_clear(viol_clear), .irq(irq)
	);

	ahbl_burst_master #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_master (
		.clk(clk), .rst_n(rst_n),
		.start_pulse(start_pulse), .mode_write(mode_write), .xfer_size(xfer_size),
		.base_addr(base_addr), .beat_count(beat_count), .pattern(pattern),
		.hready(hready), .hrdata(hrdata),
		.haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hsize(hsize),
		.hburst(hburst), .hwdata(hwdata),
		.busy(busy), .done_pulse(done_pulse), .result_sum(result_sum)
	);

	ahbl_sram #(
		.ADDR_W(ADDR_W), .DATA_W(DATA_W), .DEPTH(SRAM_DEPTH), .WAIT_STATES(WAIT_STATES)
	) u_sram (
		.clk(clk), .rst_n(rst_n),
		.haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hsize(hsize),
		.hwdata(hwdata), .hready(hready), .hrdata(hrdata)
	);

	// Passive, sees the same bus as the SRAM
	ahbl_master_monitor #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_monitor (
		.clk(clk), .rst_n(rst_n),
		.haddr(haddr), .hwrite(hwrite), .htrans(htrans), .hsize(hsize),
		.hburst(hburst), .hwdata(hwdata), .hready(hready),
		.clear_counts(clear_counts), .viol_clear(viol_clear),
		.nseq_count(nseq_count), .seq_count(seq_count),
		.stall_count(stall_count), .viol_flags(viol_flags)
	);

endmodule

/* testbench/ahbl_subsys_asserts.sv */
/*
 * Concurrent AHB-Lite checks bound into the subsystem top level.
 * Request and write data hold under wait states, irq after reset, and an
 * idle bus while the engine is not busy.
 */
module ahbl_subsys_asserts #(
	parameter int ADDR_W = ahbl_pkg::AHB_ADDR_W,
	parameter int DATA_W = ahbl_pkg::AHB_DATA_W
) (
	input logic              clk,
	input logic              rst_n,
	input logic [1:0]        htrans,
	input logic [ADDR_W-1:0] haddr,
	input logic [DATA_W-1:0] hwdata,
	input logic              hready,
	input logic              busy,
	input logic              irq
);
	import ahbl_pkg::*;

	int fail_count = 0;

	// Address phase frozen while the slave stalls
	assert property (@(posedge clk) disable iff (!rst_n)
		(htrans != HTRANS_IDLE && !hready) |=> (htrans == $past(htrans) && haddr == $past(haddr)))
	else begin
		fail_count++;
		$error("Address phase moved while hready was low");
	end

	// hwdata only advances on an accepted beat
	assert property (@(posedge clk) disable iff (!rst_n) !hready |=> $stable(hwdata))
	else begin
		fail_count++;
		$error("hwdata changed during a stalled data phase");
	end

	assert property (@(posedge clk) $rose(rst_n) |-> !irq)
	else begin
		fail_count++;
		$error("irq high right after reset");
	end

	// No transfers outside a burst
	assert property (@(posedge clk) disable iff (!rst_n) !busy |-> htrans == HTRANS_IDLE)
	else begin
		fail_count++;
		$error("htrans active while the engine is idle");
	end

endmodule

bind ahbl_subsys_top ahbl_subsys_asserts #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_asserts (
	.clk(clk), .rst_n(rst_n), .htrans(htrans), .haddr(haddr), .hwdata(hwdata),
	.hready(hready), .busy(busy), .irq(irq)
);

/* testbench/tb_checker.sv */
/*
 * Checker of the subsystem testbench.
 * Watches the APB port and irq, compares reads with the expected values
 * from the testbench top, prints one line per test and a closing count.
 */
module tb_checker (
	input  logic        clk,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] prdata,
	input  logic        irq,
	input  logic        chk_en,
	input  logic [31:0] exp_data,
	input  logic        irq_chk,
	input  logic        exp_irq,
	input  int          test_num,
	input  logic        test_end,
	input  logic        hang,
	input  logic        all_done,
	output int          err_count
);
	import ahbl_pkg::*;

	int errs = 0;
	int checks = 0;
	int test_checks = 0;
	int test_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;

	assign err_count = errs;

	function automatic string reg_name(input logic [7:0] a);
		case (a)
			REG_CTRL:    return "CTRL";
			REG_BASE:    return "BASE";
			REG_COUNT:   return "COUNT";
			REG_PATTERN: return "PATTERN";
			REG_STATUS:  return "STATUS";
			REG_RESULT:  return "RESULT";
			REG_XFER:    return "XFER";
			REG_STALL:   return "STALL";
			REG_VIOL:    return "VIOL";
			default:     return "UNMAPPED";
		endcase
	endfunction

	function automatic string test_title(input int n);
		case (n)
			1:       return "reset values";
			2:       return "word fill and read back";
			3:       return "stall count and irq";
			4:       return "byte and halfword fill";
			5:       return "violation flags";
			6:       return "random bursts";
			default: return "extra";
		endcase
	endfunction

	always @(posedge clk) begin
		// Register read in its access cycle
		if (psel && penable && !pwrite && chk_en) begin
			checks      = checks + 1;
			test_checks = test_checks + 1;
			if (prdata !== exp_data) begin
				errs      = errs + 1;
				test_errs = test_errs + 1;
				$display("Fail %s: expected %08h, got %08h", reg_name(paddr), exp_data, prdata);
			end
		end
		if (irq_chk) begin
			checks      = checks + 1;
			test_checks = test_checks + 1;
			if (irq !== exp_irq) begin
				errs      = errs + 1;
				test_errs = test_errs + 1;
				$display("Fail irq: expected %0h, got %0h", exp_irq, irq);
			end
		end
		if (hang) begin
			errs      = errs + 1;
			test_errs = test_errs + 1;
			$display("Test %0d: the burst never raised done, gave up waiting", test_num);
		end
		if (test_end) begin
			tests_run = tests_run + 1;
			if (test_errs != 0) begin
				tests_failed = tests_failed + 1;
				$display("Test %0d %s: failed, %0d checks, %0d errors", test_num,
					test_title(test_num), test_checks, test_errs);
			end else begin
				$display("Test %0d %s: ok, %0d checks", test_num, test_title(test_num),
					test_checks);
			end
			test_checks = 0;
			test_errs   = 0;
		end
		if (all_done)
			$display("Totals: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
				tests_failed, checks, errs);
	end

endmodule

/* testbench/tb_top.sv */
/*
 * Testbench top for the AHB-Lite fill and check subsystem.
 * Drives the APB port on falling edges and keeps a byte model of the SRAM.
 * Passes the expected register values to the checker.
 */
module tb_top;
	import ahbl_pkg::*;

	localparam int WS      = 2;
	localparam int DEPTH   = 1024;
	localparam int MEM_B   = DEPTH * 4;
	localparam int PERIOD  = 20;
	localparam int N_RAND  = 10;
	localparam int MAX_CNT = 32;
	// Beats over all bursts, the fill and read back dominate
	localparam int MAX_BEATS = 2 * DEPTH + 8 + 4 * MAX_CNT + 8 + N_RAND * MAX_CNT;
	localparam int N_BURSTS  = 9 + N_RAND;
	// Per burst margin covers the APB setup and check transfers
	localparam longint LIMIT = longint'(MAX_BEATS * (1 + WS) + N_BURSTS * 100 + 500) * PERIOD;

	logic        clk;
	logic        rst_n;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        irq;

	// Checker handshake
	logic        chk_en;
	logic [31:0] exp_data;
	logic        irq_chk;
	logic        exp_irq;
	int          test_num;
	logic        test_end;
	logic        hang;
	logic        all_done;
	int          err_count;

	integer      seed;
	int          cycles;
	logic [7:0]  mem_model [MEM_B];

	ahbl_subsys_top #(.SRAM_DEPTH(DEPTH), .WAIT_STATES(WS)) UUT (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .irq(irq)
	);

	tb_checker u_checker (
		.clk(clk), .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.prdata(prdata), .irq(irq), .chk_en(chk_en), .exp_data(exp_data),
		.irq_chk(irq_chk), .exp_irq(exp_irq), .test_num(test_num),
		.test_end(test_end), .hang(hang), .all_done(all_done), .err_count(err_count)
	);

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cycles <= cycles + 1;

	// Expected read sum of one INCR burst, writes go into the byte model
	function automatic logic [31:0] ref_burst(input logic wr, input int size,
			input logic [31:0] base, input int count, input logic [31:0] pat,
			output logic [31:0] xfer);
		logic [31:0] sum;
		logic [31:0] addr;
		logic [31:0] val;
		logic [31:0] beat;
		int          unit;
		sum  = 32'd0;
		unit = (size > 2) ? 4 : (1 << size);
		for (int i = 0; i < count; i++) begin
			// Address steps one size unit, data is pattern plus beat index
			addr = base + i * unit;
			val  = pat + i;
			beat = 32'd0;
			for (int k = 0; k < unit; k++) begin
				if (wr)
					mem_model[(addr + k) % MEM_B] = val[8*k +: 8];
				else
					beat[8*k +: 8] = mem_model[(addr + k) % MEM_B];
			end
			if (!wr)
				sum = sum + beat;
		end
		// One NONSEQ then SEQ for the rest
		xfer = {16'(count - 1), 16'd1};
		return sum;
	endfunction

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		paddr  = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel   = 1'b1;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge clk);
		paddr  = addr;
		pwrite = 1'b0;
		psel   = 1'b1;
		@(negedge clk);
		penable = 1'b1;
		// prdata is valid through the access cycle
		@(posedge clk);
		data = prdata;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		chk_en  = 1'b0;
	endtask

	task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] dummy;
		exp_data = exp;
		chk_en   = 1'b1;
		apb_read(addr, dummy);
	endtask

	task automatic check_irq(input logic exp);
		@(negedge clk);
		exp_irq = exp;
		irq_chk = 1'b1;
		@(negedge clk);
		irq_chk = 1'b0;
	endtask

	task automatic flag_hang();
		@(negedge clk);
		hang = 1'b1;
		@(negedge clk);
		hang = 1'b0;
	endtask

	task automatic end_test();
		@(negedge clk);
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
		test_num = test_num + 1;
	endtask

	// Program, start, wait for done, then check counters and irq
	task automatic run_burst(input logic wr, input int size, input logic [31:0] base,
			input int count, input logic [31:0] pat, input logic chk_res);
		logic [31:0] exp_sum;
		logic [31:0] exp_xfer;
		logic [31:0] st;
		int          t0;
		exp_sum = ref_burst(wr, size, base, count, pat, exp_xfer);
		apb_write(REG_BASE, base);
		apb_write(REG_COUNT, count);
		apb_write(REG_PATTERN, pat);
		apb_write(REG_CTRL, {27'd0, 3'(size), wr, 1'b1});
		t0 = cycles;
		st = 32'd0;
		while (!st[1] && (cycles - t0) < count * (1 + WS) + 40)
			apb_read(REG_STATUS, st);
		if (!st[1]) begin
			flag_hang();
		end else begin
			check_irq(1'b1);
			if (chk_res)
				check_reg(REG_RESULT, exp_sum);
			check_reg(REG_XFER, exp_xfer);
			check_reg(REG_STALL, count * WS);
			// Write 1 to done drops irq
			apb_write(REG_STATUS, 32'h2);
			check_irq(1'b0);
			check_reg(REG_STATUS, 32'h0);
		end
	endtask

	initial begin
		logic [31:0] b;
		logic [31:0] pat;
		logic [31:0] r;
		int          c1;
		int          c2;
		int          sz;
		int          cnt;
		seed     = 32'ha0a0;
		cycles   = 0;
		clk      = 1'b0;
		rst_n    = 1'b0;
		paddr    = 8'd0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		pwdata   = 32'd0;
		chk_en   = 1'b0;
		exp_data = 32'd0;
		irq_chk  = 1'b0;
		exp_irq  = 1'b0;
		test_num = 1;
		test_end = 1'b0;
		hang     = 1'b0;
		all_done = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// Reset values
		check_reg(REG_STATUS, 32'd0);
		check_reg(REG_XFER, 32'd0);
		check_reg(REG_STALL, 32'd0);
		check_reg(REG_VIOL, 32'd0);
		check_reg(REG_RESULT, 32'd0);
		check_irq(1'b0);
		end_test();

		// Fill the whole SRAM with words, then read it all back
		pat = $random(seed);
		run_burst(1'b1, 2, 32'd0, DEPTH, pat, 1'b1);
		run_burst(1'b0, 2, 32'd0, DEPTH, 32'd0, 1'b1);
		check_reg(REG_VIOL, 32'd0);
		end_test();

		// Short burst for stall count and irq
		run_burst(1'b1, 2, 32'h200, 8, $random(seed), 1'b1);
		end_test();

		// Byte then halfword fills, read back as words
		c1 = 1 + ($random(seed) & 31);
		b  = $random(seed) & 32'hffc;
		run_burst(1'b1, 0, b, c1, $random(seed), 1'b1);
		run_burst(1'b0, 2, b, (c1 + 3) / 4, 32'd0, 1'b1);
		c2 = 1 + ($random(seed) & 31);
		b  = $random(seed) & 32'hffe;
		run_burst(1'b1, 1, b, c2, $random(seed), 1'b1);
		run_burst(1'b0, 2, b & ~32'd3, (int'(b[1:0]) + 2 * c2 + 3) / 4, 32'd0, 1'b1);
		check_reg(REG_VIOL, 32'd0);
		end_test();

		// Unaligned halfword, then a size wider than the bus
		b = $random(seed) & 32'hff0;
		run_burst(1'b0, 1, b | 32'd1, 4, 32'd0, 1'b0);
		check_reg(REG_VIOL, 32'd1 << VIOL_ALIGN);
		apb_write(REG_VIOL, 32'd1 << VIOL_ALIGN);
		check_reg(REG_VIOL, 32'd0);
		run_burst(1'b0, 3, b, 4, 32'd0, 1'b0);
		check_reg(REG_VIOL, 32'd1 << VIOL_SIZE);
		apb_write(REG_VIOL, 32'd1 << VIOL_SIZE);
		check_reg(REG_VIOL, 32'd0);
		end_test();

		// Random legal configurations
		for (int n = 0; n < N_RAND; n++) begin
			r   = $random(seed);
			sz  = $unsigned($random(seed)) % 3;
			cnt = 1 + ($random(seed) & (MAX_CNT - 1));
			b   = $random(seed) & 32'hfff;
			b   = b & ~((32'd1 << sz) - 32'd1);
			run_burst(r[0], sz, b, cnt, $random(seed), 1'b1);
			check_reg(REG_VIOL, 32'd0);
		end
		end_test();

		@(negedge clk);
		all_done = 1'b1;
		@(negedge clk);
		all_done = 1'b0;
		if (err_count == 0 && UUT.u_asserts.fail_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT);
		$display("Watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* flist.f */
hdl/ahbl_pkg.sv
hdl/apb_regs.sv
hdl/ahbl_burst_master.sv
hdl/ahbl_sram.sv
hdl/ahbl_master_monitor.sv
hdl/ahbl_subsys_top.sv
testbench/ahbl_subsys_asserts.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
